/* wisc_macros.svh */
`ifndef WISC_MACROS_SVH
`define WISC_MACROS_SVH

// Machine word and register file geometry
`define WISC_DATA_W   16
`define WISC_NUM_REGS 8
`define WISC_REG_W    3

// JAL writes its return address here
`define WISC_LINK_REG 7

`endif

/* isa_pkg.sv */
package isa_pkg;

  // Primary opcode, instruction bits 15 to 11
  typedef enum logic [4:0] {
    HALT  = 5'b00000,
    NOP   = 5'b00001,
    J     = 5'b00100,  // PC-relative jump, 11-bit displacement
    JAL   = 5'b00110,  // Jump and link
    ADDI  = 5'b01000,
    SUBI  = 5'b01001,
    XORI  = 5'b01010,
    ANDNI = 5'b01011,
    BEQZ  = 5'b01100,
    BNEZ  = 5'b01101,
    ST    = 5'b10000,
    LD    = 5'b10001,
    SLBI  = 5'b10010,  // Shift left and load byte
    STU   = 5'b10011,  // Store with base update
    LBI   = 5'b11000,
    RTYPE = 5'b11011   // Register-register ALU group
  } opcode_e;

  // R-format function field, bits 1 to 0
  typedef enum logic [1:0] {
    ADD  = 2'b00,
    SUB  = 2'b01,
    XOR  = 2'b10,
    ANDN = 2'b11
  } func_e;

  // Where the immediate comes from and how it is widened
  typedef enum logic [2:0] {
    NONE   = 3'd0,  // No immediate, output zero
    SEXT5  = 3'd1,
    ZEXT5  = 3'd2,
    SEXT8  = 3'd3,
    ZEXT8  = 3'd4,
    SEXT11 = 3'd5
  } imm_kind_e;

endpackage

/* decode_pkg.sv */
`include "wisc_macros.svh"

package decode_pkg;

  // Fetch to decode
  typedef struct packed {
    logic                    valid;
    logic [`WISC_DATA_W-1:0] instr;
    logic [4:0]              pc_hi;  // Upper PC bits for jump target
  } if_id_t;

  // Register write from writeback
  typedef struct packed {
    logic                    we;
    logic [`WISC_REG_W-1:0]  wr_reg;
    logic [`WISC_DATA_W-1:0] wr_data;
  } wb_t;

  // Control bundle carried to execute
  typedef struct packed {
    isa_pkg::opcode_e   op;
    isa_pkg::func_e     func;       // Meaningful for RTYPE only
    isa_pkg::imm_kind_e imm_kind;
    logic               reg_write;
    logic               mem_read;
    logic               mem_write;
    logic               branch;
    logic               jump;
    logic               halt;
  } ctrl_t;

  // Decode to execute pipeline register
  typedef struct packed {
    logic                    valid;
    ctrl_t                   ctrl;
    logic [`WISC_DATA_W-1:0] op_a;         // Register in bits 10 to 8
    logic [`WISC_DATA_W-1:0] op_b;         // Register in bits 7 to 5
    logic [`WISC_DATA_W-1:0] imm;
    logic [`WISC_DATA_W-1:0] jump_target;
    logic [`WISC_REG_W-1:0]  wr_reg;
  } id_ex_t;

endpackage

/* reg_file.sv */
`include "wisc_macros.svh"

module reg_file (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic [`WISC_REG_W-1:0]  rd_a_sel,
  input  logic [`WISC_REG_W-1:0]  rd_b_sel,
  output logic [`WISC_DATA_W-1:0] rd_a,
  output logic [`WISC_DATA_W-1:0] rd_b,
  input  decode_pkg::wb_t         wb
);

  logic [`WISC_DATA_W-1:0] regs [`WISC_NUM_REGS];
  logic                    byp_a;
  logic                    byp_b;

  // Write port, register 0 is not hardwired
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `WISC_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.we) begin
      regs[wb.wr_reg] <= wb.wr_data;
    end
  end

  // Same-cycle write shows up on the read ports
  assign byp_a = wb.we && (wb.wr_reg == rd_a_sel);
  assign byp_b = wb.we && (wb.wr_reg == rd_b_sel);

  assign rd_a = byp_a ? wb.wr_data : regs[rd_a_sel];
  assign rd_b = byp_b ? wb.wr_data : regs[rd_b_sel];

  // Writeback must name a real register whenever it writes
  a_wr_reg_known: assert property (
    @(posedge clk) disable iff (!arst_n)
    wb.we |-> !$isunknown(wb.wr_reg)
  ) else $error("reg_file: write with unknown register index");

endmodule

/* ctrl_decode.sv */
module ctrl_decode (
  input  logic [15:0]       instr,
  output decode_pkg::ctrl_t ctrl,
  output logic              illegal
);

  logic [4:0] opcode;

  assign opcode = instr[15:11];

  always_comb begin
    ctrl     = '0;
    illegal  = 1'b0;
    ctrl.op  = isa_pkg::opcode_e'(opcode);

    case (opcode)
      isa_pkg::HALT: begin
        ctrl.halt = 1'b1;
      end
      isa_pkg::NOP: begin
        ctrl.imm_kind = isa_pkg::NONE;  // Nothing to do downstream
      end
      isa_pkg::J: begin
        ctrl.jump     = 1'b1;
        ctrl.imm_kind = isa_pkg::SEXT11;
      end
      isa_pkg::JAL: begin
        ctrl.jump      = 1'b1;
        ctrl.reg_write = 1'b1;  // Return address to link register
        ctrl.imm_kind  = isa_pkg::SEXT11;
      end
      isa_pkg::ADDI,
      isa_pkg::SUBI: begin
        ctrl.reg_write = 1'b1;
        ctrl.imm_kind  = isa_pkg::SEXT5;
      end
      // Logical immediates are unsigned
      isa_pkg::XORI,
      isa_pkg::ANDNI: begin
        ctrl.reg_write = 1'b1;
        ctrl.imm_kind  = isa_pkg::ZEXT5;
      end
      isa_pkg::BEQZ,
      isa_pkg::BNEZ: begin
        ctrl.branch   = 1'b1;
        ctrl.imm_kind = isa_pkg::SEXT8;
      end
      isa_pkg::ST: begin
        ctrl.mem_write = 1'b1;
        ctrl.imm_kind  = isa_pkg::SEXT5;
      end
      isa_pkg::LD: begin
        ctrl.mem_read  = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.imm_kind  = isa_pkg::SEXT5;
      end
      isa_pkg::STU: begin
        ctrl.mem_write = 1'b1;
        ctrl.reg_write = 1'b1;  // Base register gets the new address
        ctrl.imm_kind  = isa_pkg::SEXT5;
      end
      isa_pkg::LBI: begin
        ctrl.reg_write = 1'b1;
        ctrl.imm_kind  = isa_pkg::SEXT8;
      end
      isa_pkg::SLBI: begin
        ctrl.reg_write = 1'b1;
        ctrl.imm_kind  = isa_pkg::ZEXT8;
      end
      isa_pkg::RTYPE: begin
        ctrl.reg_write = 1'b1;
        ctrl.func      = isa_pkg::func_e'(instr[1:0]);
      end
      default: begin
        // Unknown opcode, no side effects at all
        ctrl    = '0;
        illegal = 1'b1;
      end
    endcase
  end

endmodule

/* imm_extend.sv */
module imm_extend (
  input  logic [15:0]        instr,
  input  isa_pkg::imm_kind_e kind,
  output logic [15:0]        imm
);

  // Single select replaces separate extenders and muxes
  always_comb begin
    case (kind)
      isa_pkg::SEXT5: begin
        imm = {{11{instr[4]}}, instr[4:0]};
      end
      isa_pkg::ZEXT5: begin
        imm = {11'd0, instr[4:0]};
      end
      isa_pkg::SEXT8: begin
        imm = {{8{instr[7]}}, instr[7:0]};
      end
      isa_pkg::ZEXT8: begin
        imm = {8'd0, instr[7:0]};
      end
      isa_pkg::SEXT11: begin
        imm = {{5{instr[10]}}, instr[10:0]};  // Jump displacement
      end
      default: begin
        imm = '0;  // NONE and unused codes
      end
    endcase
  end

endmodule

/* instr_decode.sv */
`include "wisc_macros.svh"

module instr_decode (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic [15:0]             instr,
  input  logic [4:0]              pc_hi,
  input  decode_pkg::wb_t         wb,
  output decode_pkg::ctrl_t       ctrl,
  output logic [15:0]             op_a,
  output logic [15:0]             op_b,
  output logic [15:0]             imm,
  output logic [15:0]             jump_target,
  output logic [`WISC_REG_W-1:0]  wr_reg,
  output logic                    illegal
);

  logic [`WISC_REG_W-1:0] rs_a;  // Bits 10 to 8
  logic [`WISC_REG_W-1:0] rs_b;  // Bits 7 to 5
  logic [`WISC_REG_W-1:0] rd_r;  // R-format destination, bits 4 to 2

  assign rs_a = instr[10:8];
  assign rs_b = instr[7:5];
  assign rd_r = instr[4:2];

  ctrl_decode u_ctrl_decode (
    .instr   (instr),
    .ctrl    (ctrl),
    .illegal (illegal)
  );

  reg_file u_reg_file (
    .clk      (clk),
    .arst_n   (arst_n),
    .rd_a_sel (rs_a),
    .rd_b_sel (rs_b),
    .rd_a     (op_a),
    .rd_b     (op_b),
    .wb       (wb)
  );

  imm_extend u_imm_extend (
    .instr (instr),
    .kind  (ctrl.imm_kind),
    .imm   (imm)
  );

  // Destination register select
  always_comb begin
    case (ctrl.op)
      isa_pkg::RTYPE: wr_reg = rd_r;
      isa_pkg::ADDI,
      isa_pkg::SUBI,
      isa_pkg::XORI,
      isa_pkg::ANDNI,
      isa_pkg::LD:    wr_reg = rs_b;
      // These write back into the first source field
      isa_pkg::LBI,
      isa_pkg::SLBI,
      isa_pkg::STU:   wr_reg = rs_a;
      isa_pkg::JAL:   wr_reg = `WISC_REG_W'(`WISC_LINK_REG);
      default:        wr_reg = '0;
    endcase
  end

  assign jump_target = {pc_hi, instr[10:0]};  // Page from PC, offset from instr

endmodule

/* decode_stage.sv */
module decode_stage (
  input  logic               clk,
  input  logic               arst_n,
  input  decode_pkg::if_id_t if_id,
  input  decode_pkg::wb_t    wb,
  input  logic               stall,
  output decode_pkg::id_ex_t id_ex,
  output logic               err
);

  decode_pkg::ctrl_t ctrl;
  logic [15:0]       op_a;
  logic [15:0]       op_b;
  logic [15:0]       imm;
  logic [15:0]       jump_target;
  logic [2:0]        wr_reg;
  logic              illegal;

  instr_decode u_instr_decode (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr       (if_id.instr),
    .pc_hi       (if_id.pc_hi),
    .wb          (wb),
    .ctrl        (ctrl),
    .op_a        (op_a),
    .op_b        (op_b),
    .imm         (imm),
    .jump_target (jump_target),
    .wr_reg      (wr_reg),
    .illegal     (illegal)
  );

  // Decode to execute register, frozen while execute stalls
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      id_ex <= '0;
    end else if (!stall) begin
      id_ex.valid       <= if_id.valid;
      id_ex.ctrl        <= if_id.valid ? ctrl : '0;  // Bubbles carry no control
      id_ex.op_a        <= op_a;
      id_ex.op_b        <= op_b;
      id_ex.imm         <= imm;
      id_ex.jump_target <= jump_target;
      id_ex.wr_reg      <= wr_reg;
    end
  end

  assign err = if_id.valid & illegal;

  // Execute relies on the bundle not moving under a stall
  a_hold_on_stall: assert property (
    @(posedge clk) disable iff (!arst_n)
    stall |=> $stable(id_ex)
  ) else $error("decode_stage: id_ex changed during stall");

endmodule

/* tb_clock_gen.sv */
module tb_clock_gen (
  output logic clk,
  output logic arst_n
);
  timeunit 1ns;
  timeprecision 1ps;

  initial clk = 1'b0;
  always #10 clk = ~clk;  // 20 ns period

  // Reset held for 10 cycles, released away from the rising edge
  initial begin
    arst_n = 1'b0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
  end

endmodule

/* tb_decode_stage.sv */
`include "wisc_macros.svh"

module tb_decode_stage;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD_NS = 20;
  localparam int CYCLE_BUDGET  = 12 + 10 + 20 + 24 + 20 + 40 + 18;  // Reset plus six tests

  logic                    clk;
  logic                    arst_n;
  decode_pkg::if_id_t      if_id;
  decode_pkg::wb_t         wb;
  logic                    stall;
  decode_pkg::id_ex_t      id_ex;
  logic                    err;
  logic [`WISC_DATA_W-1:0] shadow [`WISC_NUM_REGS];  // Expected register contents
  decode_pkg::id_ex_t      held;                     // Last expected output
  integer                  seed;
  int                      checks;
  int                      errors;

  tb_clock_gen u_clk (
    .clk    (clk),
    .arst_n (arst_n)
  );

  decode_stage u_dut (
    .clk    (clk),
    .arst_n (arst_n),
    .if_id  (if_id),
    .wb     (wb),
    .stall  (stall),
    .id_ex  (id_ex),
    .err    (err)
  );

  task automatic check_word(input string name, input logic [15:0] exp, input logic [15:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error at %0d ns: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_reg(input string name, input logic [2:0] exp, input logic [2:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error at %0d ns: %s expected %0d, got %0d", $time, name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error at %0d ns: %s expected %b, got %b", $time, name, exp, act);
    end
  endtask

  task automatic check_ctrl(input string name, input decode_pkg::ctrl_t exp,
                            input decode_pkg::ctrl_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error at %0d ns: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  // Encodings straight from the opcode table
  function automatic logic is_legal(input logic [4:0] op);
    case (op)
      5'b00000, 5'b00001, 5'b00100, 5'b00110, 5'b01000, 5'b01001,
      5'b01010, 5'b01011, 5'b10000, 5'b10001, 5'b10011, 5'b01100,
      5'b01101, 5'b11000, 5'b10010, 5'b11011: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic decode_pkg::ctrl_t expect_ctrl(input logic [15:0] instr);
    decode_pkg::ctrl_t c;
    isa_pkg::opcode_e  op;
    c  = '0;
    op = isa_pkg::opcode_e'(instr[15:11]);
    if (!is_legal(instr[15:11])) return c;
    c.op        = op;
    c.reg_write = op inside {isa_pkg::ADDI, isa_pkg::SUBI, isa_pkg::XORI, isa_pkg::ANDNI,
                             isa_pkg::RTYPE, isa_pkg::LD, isa_pkg::STU, isa_pkg::LBI,
                             isa_pkg::SLBI, isa_pkg::JAL};
    c.mem_write = op inside {isa_pkg::ST, isa_pkg::STU};
    c.mem_read  = (op == isa_pkg::LD);
    c.branch    = op inside {isa_pkg::BEQZ, isa_pkg::BNEZ};
    c.jump      = op inside {isa_pkg::J, isa_pkg::JAL};
    c.halt      = (op == isa_pkg::HALT);
    if (op == isa_pkg::RTYPE) c.func = isa_pkg::func_e'(instr[1:0]);
    if (op inside {isa_pkg::ADDI, isa_pkg::SUBI, isa_pkg::ST, isa_pkg::LD, isa_pkg::STU})
      c.imm_kind = isa_pkg::SEXT5;
    else if (op inside {isa_pkg::XORI, isa_pkg::ANDNI})
      c.imm_kind = isa_pkg::ZEXT5;
    else if (op inside {isa_pkg::BEQZ, isa_pkg::BNEZ, isa_pkg::LBI})
      c.imm_kind = isa_pkg::SEXT8;
    else if (op == isa_pkg::SLBI)
      c.imm_kind = isa_pkg::ZEXT8;
    else if (op inside {isa_pkg::J, isa_pkg::JAL})
      c.imm_kind = isa_pkg::SEXT11;
    return c;
  endfunction

  function automatic logic [15:0] expect_imm(input logic [15:0] instr,
                                             input isa_pkg::imm_kind_e kind);
    logic signed [15:0] s;
    case (kind)
      isa_pkg::SEXT5:  s = $signed({instr[4:0], 11'd0}) >>> 11;  // Arithmetic shift widens
      isa_pkg::ZEXT5:  s = 16'(instr[4:0]);
      isa_pkg::SEXT8:  s = $signed({instr[7:0], 8'd0}) >>> 8;
      isa_pkg::ZEXT8:  s = 16'(instr[7:0]);
      isa_pkg::SEXT11: s = $signed({instr[10:0], 5'd0}) >>> 5;
      default:         s = '0;
    endcase
    return s;
  endfunction

  function automatic logic [2:0] expect_dest(input logic [15:0] instr);
    case (instr[15:11])
      5'b11011:                               return instr[4:2];
      5'b01000, 5'b01001, 5'b01010, 5'b01011,
      5'b10001:                               return instr[7:5];
      5'b11000, 5'b10010, 5'b10011:           return instr[10:8];
      5'b00110:                               return 3'd7;  // Link register
      default:                                return 3'd0;
    endcase
  endfunction

  function automatic logic [15:0] read_reg(input logic [2:0] sel, input decode_pkg::wb_t w);
    if (w.we && w.wr_reg == sel) return w.wr_data;
    return shadow[sel];
  endfunction

  function automatic decode_pkg::id_ex_t model_decode(input logic v, input logic [15:0] instr,
                                                      input logic [4:0] pc_hi,
                                                      input decode_pkg::wb_t w);
    decode_pkg::id_ex_t r;
    decode_pkg::ctrl_t  c;
    c             = expect_ctrl(instr);
    r.valid       = v;
    r.ctrl        = v ? c : '0;
    r.op_a        = read_reg(instr[10:8], w);
    r.op_b        = read_reg(instr[7:5], w);
    r.imm         = expect_imm(instr, c.imm_kind);
    r.jump_target = (16'(pc_hi) << 11) | (instr & 16'h07ff);
    r.wr_reg      = expect_dest(instr);
    return r;
  endfunction

  function automatic decode_pkg::wb_t make_wb(input logic we, input logic [2:0] r,
                                              input logic [15:0] d);
    decode_pkg::wb_t w;
    w.we      = we;
    w.wr_reg  = r;
    w.wr_data = d;
    return w;
  endfunction

  // Drives one cycle that starts and ends just after a falling edge
  task automatic step(input logic v, input logic [15:0] instr, input logic [4:0] pc_hi,
                      input logic stall_in, input decode_pkg::wb_t w);
    decode_pkg::id_ex_t exp;
    logic               exp_err;
    exp     = stall_in ? held : model_decode(v, instr, pc_hi, w);
    exp_err = v && !is_legal(instr[15:11]);
    if_id.valid = v;
    if_id.instr = instr;
    if_id.pc_hi = pc_hi;
    wb          = w;
    stall       = stall_in;
    #5;
    check_bit("err", exp_err, err);
    @(posedge clk);
    if (w.we) shadow[w.wr_reg] = w.wr_data;
    @(negedge clk);
    held = exp;
    check_bit("id_ex.valid", exp.valid, id_ex.valid);
    check_ctrl("id_ex.ctrl", exp.ctrl, id_ex.ctrl);
    check_word("id_ex.op_a", exp.op_a, id_ex.op_a);
    check_word("id_ex.op_b", exp.op_b, id_ex.op_b);
    check_word("id_ex.imm", exp.imm, id_ex.imm);
    check_word("id_ex.jump_target", exp.jump_target, id_ex.jump_target);
    check_reg("id_ex.wr_reg", exp.wr_reg, id_ex.wr_reg);
  endtask

  task automatic rand_legal(output logic [15:0] instr);
    logic [31:0] r;
    do begin
      r = $random(seed);
    end while (!is_legal(r[15:11]));
    instr = r[15:0];
  endtask

  task automatic report(input string name, input int err_before);
    $display("test %s finished with %0d errors", name, errors - err_before);
  endtask

  task automatic test_reset_state();
    int e;
    e = errors;
    check_bit("id_ex.valid", 1'b0, id_ex.valid);
    check_ctrl("id_ex.ctrl", '0, id_ex.ctrl);
    check_bit("err", 1'b0, err);
    for (int i = 0; i < `WISC_NUM_REGS; i++) begin
      step(1'b1, {5'b11011, 3'(i), 3'(i), 3'd0, 2'b00}, 5'd0, 1'b0, make_wb(1'b0, 3'd0, 16'd0));
    end
    report("reset_state", e);
  endtask

  task automatic test_reg_write_read();
    int          e;
    logic [31:0] r;
    e = errors;
    for (int i = 0; i < `WISC_NUM_REGS; i++) begin
      r = $random(seed);
      step(1'b0, 16'd0, 5'd0, 1'b0, make_wb(1'b1, 3'(i), r[15:0]));
    end
    for (int i = 0; i < `WISC_NUM_REGS; i++) begin
      step(1'b1, {5'b11011, 3'(i), 3'(7 - i), 3'(i), 2'b01}, 5'd0, 1'b0,
           make_wb(1'b0, 3'd0, 16'd0));
    end
    // Write and read of r3 in the same cycle
    step(1'b1, {5'b11011, 3'd3, 3'd3, 3'd0, 2'b00}, 5'd0, 1'b0, make_wb(1'b1, 3'd3, 16'hbeef));
    step(1'b1, {5'b11011, 3'd3, 3'd5, 3'd0, 2'b10}, 5'd0, 1'b0, make_wb(1'b1, 3'd5, 16'h1234));
    report("reg_write_read", e);
  endtask

  task automatic test_immediates();
    int          e;
    logic [31:0] r;
    logic [4:0]  ops [6];
    e   = errors;
    ops = '{5'b01000, 5'b01010, 5'b01100, 5'b10010, 5'b00100, 5'b00001};  // One per kind
    for (int k = 0; k < 6; k++) begin
      repeat (4) begin
        r = $random(seed);
        step(1'b1, {ops[k], r[10:0]}, r[15:11], 1'b0, make_wb(1'b0, 3'd0, 16'd0));
      end
    end
    report("immediates", e);
  endtask

  task automatic test_dest_ctrl();
    int               e;
    logic [31:0]      r;
    isa_pkg::opcode_e op;
    e  = errors;
    op = op.first();
    repeat (op.num()) begin
      r = $random(seed);
      step(1'b1, {op, r[10:0]}, r[15:11], 1'b0, make_wb(1'b0, 3'd0, 16'd0));
      op = op.next();
    end
    step(1'b1, {5'b00110, 11'h2a5}, 5'd0, 1'b0, make_wb(1'b0, 3'd0, 16'd0));
    check_reg("jal wr_reg", 3'd7, id_ex.wr_reg);
    step(1'b1, {5'b10011, 3'd5, 3'd2, 5'd9}, 5'd0, 1'b0, make_wb(1'b0, 3'd0, 16'd0));
    check_reg("stu wr_reg", 3'd5, id_ex.wr_reg);
    report("dest_ctrl", e);
  endtask

  task automatic test_jump_illegal();
    int          e;
    logic [31:0] r;
    e = errors;
    repeat (6) begin
      r = $random(seed);
      step(1'b1, {5'b00110, r[10:0]}, r[20:16], 1'b0, make_wb(1'b0, 3'd0, 16'd0));
    end
    for (int k = 0; k < 32; k++) begin
      r = $random(seed);
      step(1'b1, {5'(k), r[10:0]}, r[15:11], 1'b0, make_wb(1'b0, 3'd0, 16'd0));
    end
    // Unknown opcode in an empty slot keeps err low
    r = $random(seed);
    step(1'b0, {5'b11111, r[10:0]}, r[15:11], 1'b0, make_wb(1'b0, 3'd0, 16'd0));
    report("jump_illegal", e);
  endtask

  task automatic test_stall_stream();
    int          e;
    logic [15:0] a;
    logic [15:0] b;
    e = errors;
    rand_legal(a);
    rand_legal(b);
    step(1'b1, a, 5'd3, 1'b0, make_wb(1'b0, 3'd0, 16'd0));
    repeat (4) step(1'b1, b, 5'd9, 1'b1, make_wb(1'b0, 3'd0, 16'd0));  // Output frozen on a
    step(1'b1, b, 5'd9, 1'b0, make_wb(1'b0, 3'd0, 16'd0));
    repeat (8) begin
      rand_legal(a);
      step(1'b1, a, a[4:0], 1'b0, make_wb(1'b0, 3'd0, 16'd0));
    end
    step(1'b0, 16'd0, 5'd0, 1'b0, make_wb(1'b0, 3'd0, 16'd0));  // Bubble clears valid
    report("stall_stream", e);
  endtask

  initial begin
    seed   = 32'h9c4;
    checks = 0;
    errors = 0;
    held   = '0;
    if_id  = '0;
    wb     = '0;
    stall  = 1'b0;
    for (int i = 0; i < `WISC_NUM_REGS; i++) shadow[i] = '0;
    wait (arst_n === 1'b1);
    @(negedge clk);
    test_reset_state();
    test_reg_write_read();
    test_immediates();
    test_dest_ctrl();
    test_jump_illegal();
    test_stall_stream();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog at 1.5 times the summed test budget
  initial begin
    #(CLK_PERIOD_NS * CYCLE_BUDGET * 3 / 2);
    $display("watchdog: tests did not finish within the cycle budget");
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

/* src.f */
+incdir+.
isa_pkg.sv
decode_pkg.sv
reg_file.sv
ctrl_decode.sv
imm_extend.sv
instr_decode.sv
decode_stage.sv
tb_clock_gen.sv
tb_decode_stage.sv

/* Makefile */
# Verilator build and run for the decode stage testbench

TOP := tb_decode_stage

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check sim.log for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
